/* sim.f */
+incdir+include
rtl/csr_pkg.sv
rtl/csr_file.sv
rtl/trap_ctrl.sv
rtl/pipe_flush_ctrl.sv
rtl/mtimer_apb.sv
rtl/csr_subsys_top.sv
testbench/csr_subsys_sva.sv
testbench/csr_checker.sv
testbench/tb_csr_subsys.sv

/* Bender.yml */
package:
  name: csr_subsys

sources:
  - include_dirs:
      - include
    files:
      - rtl/csr_pkg.sv
      - rtl/csr_file.sv
      - rtl/trap_ctrl.sv
      - rtl/pipe_flush_ctrl.sv
      - rtl/mtimer_apb.sv
      - rtl/csr_subsys_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/csr_subsys_sva.sv
      - testbench/csr_checker.sv
      - testbench/tb_csr_subsys.sv

/* testbench/tb_csr_subsys.sv */
`timescale 1ns/1ps
`include "csr_defines.svh"

module tb_csr_subsys;

	localparam int N_CSR_OPS  = 400;
	localparam int N_APB_OPS  = 150;
	localparam int N_MIX_OPS  = 400;
	localparam int WAIT_LIMIT = 40;
	// all planned cycles at 8 ns, doubled as margin
	localparam int TIMEOUT_NS =
		(N_CSR_OPS + 2 * N_APB_OPS + N_MIX_OPS + 6 * WAIT_LIMIT + 100) * 8 * 2;

	logic                clk;
	logic                rst_n;
	csr_pkg::csr_req_t   csr_req;
	csr_pkg::pipe_stat_t pipe_stat;
	logic                meip;
	csr_pkg::apb_req_t   apb_req;
	logic [31:0]         csr_rdata;
	logic [31:0]         irq_addr;
	logic [31:0]         mepc;
	csr_pkg::flush_t     flush;
	logic                ack;
	csr_pkg::apb_rsp_t   apb_rsp;
	int unsigned         total_errors;

	csr_subsys_top uut (
		.clk_i       (clk),
		.reset_i     (rst_n),
		.csr_req_i   (csr_req),
		.pipe_stat_i (pipe_stat),
		.meip_i      (meip),
		.apb_req_i   (apb_req),
		.csr_rdata_o (csr_rdata),
		.irq_addr_o  (irq_addr),
		.mepc_o      (mepc),
		.flush_o     (flush),
		.ack_o       (ack),
		.apb_rsp_o   (apb_rsp)
	);

	csr_checker chk (
		.clk_i       (clk),
		.reset_i     (rst_n),
		.csr_req_i   (csr_req),
		.pipe_stat_i (pipe_stat),
		.meip_i      (meip),
		.apb_req_i   (apb_req),
		.csr_rdata_i (csr_rdata),
		.irq_addr_i  (irq_addr),
		.mepc_i      (mepc),
		.flush_i     (flush),
		.ack_i       (ack),
		.apb_rsp_i   (apb_rsp)
	);

	always #4 clk = ~clk;

	task automatic next_cycle();
		@(posedge clk);
		#1; // inputs change just after the edge
	endtask

	function automatic logic [11:0] pick_csr_addr();
		case ($urandom_range(0, 8))
			0:       return `CSR_MSTATUS;
			1:       return `CSR_MIE;
			2:       return `CSR_MTVEC;
			3:       return `CSR_MSCRATCH;
			4:       return `CSR_MEPC;
			5:       return `CSR_MCAUSE;
			6:       return `CSR_MIP;
			default: return 12'($urandom); // mostly unmapped
		endcase
	endfunction

	function automatic logic [31:0] pick_tmr_addr();
		case ($urandom_range(0, 3))
			0:       return `TMR_MTIME_OFS;
			1:       return `TMR_MTIMECMP_OFS;
			2:       return 32'h0000_0008;
			default: return $urandom | 32'h0000_0100; // never a timer offset
		endcase
	endfunction

	function automatic csr_pkg::pipe_stat_t rand_pipe(input logic allow_mret);
		csr_pkg::pipe_stat_t ps;
		ps    = 39'({$urandom, $urandom});
		ps.pc = $urandom & 32'hFFFF_FFFC;
		ps.mret_wb = allow_mret && ($urandom_range(0, 7) == 0);
		if (!allow_mret)
			ps.mret_id = 1'b0;
		return ps;
	endfunction

	task automatic csr_cycle(input logic [11:0] raddr, input logic [11:0] waddr,
		input logic [31:0] wdata, input logic wen);
		csr_req.raddr = raddr;
		csr_req.waddr = waddr;
		csr_req.wdata = wdata;
		csr_req.wen   = wen;
		next_cycle();
	endtask

	task automatic csr_write(input logic [11:0] addr, input logic [31:0] data);
		csr_cycle(addr, addr, data, 1'b1);
		csr_req.wen = 1'b0;
	endtask

	task automatic csr_read(input logic [11:0] addr);
		csr_cycle(addr, 12'h0, 32'h0, 1'b0);
	endtask

	task automatic apb_xfer(input logic [31:0] addr, input logic write, input logic [31:0] data);
		apb_req.psel    = 1'b1;
		apb_req.penable = 1'b0; // setup
		apb_req.pwrite  = write;
		apb_req.paddr   = addr;
		apb_req.pwdata  = data;
		next_cycle();
		apb_req.penable = 1'b1; // access
		next_cycle();
		apb_req = '0;
	endtask

	// ack for external entry, seq_sel low for any entry
	task automatic wait_for_trap(input logic expect_ack, input string what);
		int n;
		n = 0;
		while (!(expect_ack ? ack : !flush.seq_sel) && n < WAIT_LIMIT)
		begin
			pipe_stat = rand_pipe(1'b0);
			next_cycle();
			n++;
		end
		if (n == WAIT_LIMIT)
			chk.report_problem({what, " was never taken"});
		repeat (3)
		begin
			pipe_stat = rand_pipe(1'b0);
			next_cycle();
		end
	endtask

	initial
	begin
		#(TIMEOUT_NS);
		$display("ERROR: watchdog expired at %0t, the run did not finish", $time);
		$display("Test FAILED");
		$finish;
	end

	initial
	begin
		clk       = 1'b0;
		rst_n     = 1'b0;
		csr_req   = '0;
		pipe_stat = '0;
		meip      = 1'b0;
		apb_req   = '0;
		void'($urandom(84445));
		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;

		for (int i = 0; i < N_CSR_OPS; i++)
		begin
			pipe_stat = rand_pipe(1'b1);
			csr_cycle(pick_csr_addr(), pick_csr_addr(), $urandom, 1'($urandom_range(0, 1)));
		end

		pipe_stat = rand_pipe(1'b0);
		for (int i = 0; i < N_APB_OPS; i++)
			apb_xfer(pick_tmr_addr(), 1'($urandom_range(0, 1)), $urandom);

		apb_xfer(`TMR_MTIMECMP_OFS, 1'b1, 32'hFFFF_FFFF); // timer quiet again
		apb_xfer(`TMR_MTIME_OFS, 1'b1, 32'h0);
		repeat (4) next_cycle();
		csr_write(`CSR_MSTATUS, 32'h0);

		// external interrupt, direct mode
		csr_write(`CSR_MTVEC, $urandom & 32'hFFFF_FFFC);
		csr_write(`CSR_MIE, 32'h800);
		csr_write(`CSR_MSTATUS, 32'h8);
		meip = 1'b1;
		wait_for_trap(1'b1, "external interrupt");
		meip = 1'b0;
		csr_read(`CSR_MCAUSE);
		csr_read(`CSR_MSTATUS);

		// timer compare just ahead of mtime
		csr_write(`CSR_MIE, 32'h080);
		csr_write(`CSR_MSTATUS, 32'h8);
		apb_xfer(`TMR_MTIME_OFS, 1'b1, 32'h100);
		apb_xfer(`TMR_MTIMECMP_OFS, 1'b1, 32'h10C);
		wait_for_trap(1'b0, "timer interrupt");
		csr_read(`CSR_MCAUSE);

		// both pending when mie goes high, external wins
		csr_write(`CSR_MIE, 32'h880);
		meip = 1'b1;
		csr_write(`CSR_MSTATUS, 32'h8);
		wait_for_trap(1'b1, "simultaneous interrupt");
		csr_read(`CSR_MCAUSE);

		meip = 1'b0;
		apb_xfer(`TMR_MTIMECMP_OFS, 1'b1, 32'hFFFF_FFFF);
		csr_write(`CSR_MTVEC, ($urandom & 32'hFFFF_FFFC) | 32'h1); // vectored
		repeat (3) next_cycle();
		pipe_stat.mret_wb = 1'b1;
		csr_write(`CSR_MSTATUS, 32'h0); // mret must win
		pipe_stat.mret_wb = 1'b0;
		csr_read(`CSR_MSTATUS);

		for (int i = 0; i < N_MIX_OPS; i++)
		begin
			meip      = ($urandom_range(0, 15) == 0);
			pipe_stat = rand_pipe(1'b1);
			csr_cycle(pick_csr_addr(), pick_csr_addr(), $urandom, 1'($urandom_range(0, 1)));
		end
		repeat (3) next_cycle();

		total_errors = chk.error_count + uut.u_sva.fail_count;
		$display("checks: %0d, errors: %0d, assertion failures: %0d",
			chk.check_count, total_errors, uut.u_sva.fail_count);
		if (total_errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

/* testbench/csr_checker.sv */
`timescale 1ns/1ps
`include "csr_defines.svh"

module csr_checker (
	input logic                clk_i,
	input logic                reset_i,
	input csr_pkg::csr_req_t   csr_req_i,
	input csr_pkg::pipe_stat_t pipe_stat_i,
	input logic                meip_i,
	input csr_pkg::apb_req_t   apb_req_i,
	input logic [31:0]         csr_rdata_i,
	input logic [31:0]         irq_addr_i,
	input logic [31:0]         mepc_i,
	input csr_pkg::flush_t     flush_i,
	input logic                ack_i,
	input csr_pkg::apb_rsp_t   apb_rsp_i
);

	int unsigned          error_count = 0;
	int unsigned          check_count = 0;
	logic                 st_mie;
	logic                 st_mpie;
	logic                 ie_ext;
	logic                 ie_tmr;
	logic                 ip_ext;
	logic                 ip_tmr;
	logic [31:0]          mtvec;
	logic [31:0]          mscratch;
	logic [31:0]          mepc;
	logic [31:0]          mcause;
	logic [31:0]          rdata;
	logic [31:0]          mtime;
	logic [31:0]          mtimecmp;
	logic                 mtip;
	logic [30:0]          cause;
	logic                 take;
	logic                 apb_access;
	csr_pkg::trap_state_e state;
	csr_pkg::trap_state_e nxt;

	assign take       = st_mie & ((ie_ext & ip_ext) | (ie_tmr & ip_tmr));
	assign apb_access = apb_req_i.psel & apb_req_i.penable;

	function automatic logic [31:0] csr_value(input logic [11:0] addr);
		case (addr)
			`CSR_MSTATUS:  return (32'(`MPP_MACHINE) << 11) | (32'(st_mpie) << 7) | (32'(st_mie) << 3);
			`CSR_MIE:      return (32'(ie_ext) << 11) | (32'(ie_tmr) << 7);
			`CSR_MTVEC:    return mtvec;
			`CSR_MSCRATCH: return mscratch;
			`CSR_MEPC:     return mepc;
			`CSR_MCAUSE:   return mcause;
			`CSR_MIP:      return (32'(ip_ext) << 11) | (32'(ip_tmr) << 7);
			default:       return 32'h0;
		endcase
	endfunction

	task automatic write_csr(input logic [11:0] addr, input logic [31:0] data);
		case (addr)
			`CSR_MSTATUS:
			begin
				st_mie  = data[3];
				st_mpie = data[7];
			end
			`CSR_MIE:
			begin
				ie_ext = data[11];
				ie_tmr = data[7];
			end
			`CSR_MTVEC:    mtvec    = data & 32'hFFFF_FFFD; // bit 1 reserved
			`CSR_MSCRATCH: mscratch = data;
			`CSR_MEPC:     mepc     = data & 32'hFFFF_FFFC;
			`CSR_MCAUSE:   mcause   = data;
			default:       ;
		endcase
	endtask

	task automatic compare(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		check_count++;
		if (actual !== expected)
		begin
			error_count++;
			$display("FAILED %s expected %h actual %h at %0t", name, expected, actual, $time);
		end
	endtask

	task automatic report_problem(input string what);
		error_count++;
		$display("ERROR: %s at %0t", what, $time);
	endtask

	// model state advances on the same edge as the DUT
	always @(posedge clk_i or negedge reset_i)
	begin
		if (!reset_i)
		begin
			{st_mie, st_mpie, ie_ext, ie_tmr, ip_ext, ip_tmr, mtip} = '0;
			{mtvec, mscratch, mepc, mcause, rdata, mtime} = '0;
			mtimecmp = '1;
			state    = csr_pkg::INIT;
		end
		else
		begin
			rdata = csr_value(csr_req_i.raddr);
			if (state == csr_pkg::STAND_BY && take)
				cause = (ie_ext & ip_ext) ? `CAUSE_M_EXT : `CAUSE_M_TIMER;
			case (state)
				csr_pkg::INIT:       nxt = csr_pkg::STAND_BY;
				csr_pkg::STAND_BY:   nxt = take ? csr_pkg::TRAP_ENTER : csr_pkg::STAND_BY;
				csr_pkg::TRAP_ENTER: nxt = csr_pkg::TRAP_SETTLE;
				default:             nxt = csr_pkg::STAND_BY;
			endcase
			if (state == csr_pkg::TRAP_ENTER)
			begin
				mepc    = pipe_stat_i.pc & 32'hFFFF_FFFC;
				mcause  = {1'b1, cause};
				st_mpie = st_mie;
				st_mie  = 1'b0;
			end
			else if (pipe_stat_i.mret_wb)
			begin
				st_mie  = st_mpie;
				st_mpie = 1'b1;
			end
			else if (csr_req_i.wen)
				write_csr(csr_req_i.waddr, csr_req_i.wdata);
			ip_ext = meip_i;
			ip_tmr = mtip;                  // mip lags the compare by one more edge
			mtip   = (mtime >= mtimecmp);
			if (apb_access && apb_req_i.pwrite && apb_req_i.paddr == `TMR_MTIMECMP_OFS)
				mtimecmp = apb_req_i.pwdata;
			if (apb_access && apb_req_i.pwrite && apb_req_i.paddr == `TMR_MTIME_OFS)
				mtime = apb_req_i.pwdata;
			else
				mtime = mtime + 32'd1;
			state = nxt;
		end
	end

	// outputs compared mid-cycle
	always @(negedge clk_i)
	begin
		csr_pkg::flush_t exp_flush;
		logic            mret_take;
		logic            enter;
		logic [31:0]     base;
		logic            unmapped;
		if (reset_i)
		begin
			mret_take = pipe_stat_i.mret_id & ~pipe_stat_i.take_branch;
			enter     = (state == csr_pkg::TRAP_ENTER);
			exp_flush.flush_mem = take & pipe_stat_i.mem_wen & ~pipe_stat_i.mem_dummy;
			exp_flush.flush_ex  = exp_flush.flush_mem
				| (take & ~pipe_stat_i.ex_dummy & ~pipe_stat_i.misaligned_ex);
			exp_flush.flush_id  = exp_flush.flush_ex | take;
			exp_flush.flush_if  = take | enter | mret_take;
			exp_flush.mret_sel  = mret_take;
			exp_flush.seq_sel   = ~(enter | mret_take);
			base = mtvec & 32'hFFFF_FFFC;
			compare("csr_rdata_o", rdata, csr_rdata_i);
			compare("mepc_o", mepc, mepc_i);
			compare("irq_addr_o", mtvec[0] ? base + (mcause & 32'h7FFF_FFFF) * 32'd4 : base,
				irq_addr_i);
			compare("flush_o", exp_flush, flush_i);
			compare("ack_o", enter && (cause == `CAUSE_M_EXT), ack_i);
			compare("apb pready", 32'h1, apb_rsp_i.pready);
			if (apb_access)
			begin
				unmapped = (apb_req_i.paddr != `TMR_MTIME_OFS)
					&& (apb_req_i.paddr != `TMR_MTIMECMP_OFS);
				compare("apb pslverr", unmapped, apb_rsp_i.pslverr);
				if (!unmapped)
					compare("apb prdata",
						(apb_req_i.paddr == `TMR_MTIME_OFS) ? mtime : mtimecmp,
						apb_rsp_i.prdata);
			end
		end
	end

endmodule

/* testbench/csr_subsys_sva.sv */
`timescale 1ns/1ps

module csr_subsys_sva (
	input logic                 clk_i,
	input logic                 reset_i,
	input csr_pkg::trap_state_e trap_state_i,
	input logic                 ack_i,
	input csr_pkg::apb_req_t    apb_req_i,
	input csr_pkg::apb_rsp_t    apb_rsp_i
);

	int unsigned fail_count = 0;

	enter_then_settle: assert property (@(posedge clk_i) disable iff (!reset_i)
		trap_state_i == csr_pkg::TRAP_ENTER |=> trap_state_i == csr_pkg::TRAP_SETTLE)
	else
	begin
		fail_count++;
		$error("trap entry lasted more than one cycle");
	end

	settle_then_standby: assert property (@(posedge clk_i) disable iff (!reset_i)
		trap_state_i == csr_pkg::TRAP_SETTLE |=> trap_state_i == csr_pkg::STAND_BY)
	else
	begin
		fail_count++;
		$error("trap settle did not return to stand-by");
	end

	// single-cycle ack, only while entering
	ack_one_pulse: assert property (@(posedge clk_i) disable iff (!reset_i)
		ack_i |-> (trap_state_i == csr_pkg::TRAP_ENTER) ##1 !ack_i)
	else
	begin
		fail_count++;
		$error("ack_o outside trap entry or longer than one cycle");
	end

	// setup phase must be followed by an access that completes at once
	apb_zero_wait: assert property (@(posedge clk_i) disable iff (!reset_i)
		apb_req_i.psel && !apb_req_i.penable
			|=> apb_req_i.psel && apb_req_i.penable && apb_rsp_i.pready)
	else
	begin
		fail_count++;
		$error("APB setup not followed by an access cycle with pready high");
	end

endmodule

bind csr_subsys_top csr_subsys_sva u_sva (
	.clk_i        (clk_i),
	.reset_i      (reset_i),
	.trap_state_i (trap_state),
	.ack_i        (ack_o),
	.apb_req_i    (apb_req_i),
	.apb_rsp_i    (apb_rsp_o)
);

/* rtl/csr_subsys_top.sv */
`timescale 1ns/1ps

module csr_subsys_top (
	input  logic                clk_i,
	input  logic                reset_i,
	input  csr_pkg::csr_req_t   csr_req_i,
	input  csr_pkg::pipe_stat_t pipe_stat_i,
	input  logic                meip_i,
	input  csr_pkg::apb_req_t   apb_req_i,
	output logic [31:0]         csr_rdata_o,
	output logic [31:0]         irq_addr_o,
	output logic [31:0]         mepc_o,
	output csr_pkg::flush_t     flush_o,
	output logic                ack_o,
	output csr_pkg::apb_rsp_t   apb_rsp_o
);

	logic                 mtip;
	logic                 status_mie;
	csr_pkg::irq_bits_u   mie;
	csr_pkg::irq_bits_u   mip;
	logic [31:0]          mtvec;
	logic [31:0]          mcause;
	logic                 take_irq;
	logic                 trap_enter;
	logic [30:0]          trap_cause;
	csr_pkg::trap_state_e trap_state;

	csr_file u_csr_file (
		.clk_i        (clk_i),
		.reset_i      (reset_i),
		.csr_req_i    (csr_req_i),
		.pc_i         (pipe_stat_i.pc),
		.mret_wb_i    (pipe_stat_i.mret_wb),
		.meip_i       (meip_i),
		.mtip_i       (mtip),
		.trap_enter_i (trap_enter),
		.trap_cause_i (trap_cause),
		.csr_rdata_o  (csr_rdata_o),
		.status_mie_o (status_mie),
		.mie_o        (mie),
		.mip_o        (mip),
		.mtvec_o      (mtvec),
		.mepc_o       (mepc_o),
		.mcause_o     (mcause)
	);

	trap_ctrl u_trap_ctrl (
		.clk_i        (clk_i),
		.reset_i      (reset_i),
		.status_mie_i (status_mie),
		.mie_i        (mie),
		.mip_i        (mip),
		.mtvec_i      (mtvec),
		.mcause_i     (mcause),
		.take_irq_o   (take_irq),
		.trap_enter_o (trap_enter),
		.trap_cause_o (trap_cause),
		.trap_state_o (trap_state),
		.irq_addr_o   (irq_addr_o),
		.ack_o        (ack_o)
	);

	pipe_flush_ctrl u_pipe_flush_ctrl (
		.take_irq_i   (take_irq),
		.trap_state_i (trap_state),
		.pipe_stat_i  (pipe_stat_i),
		.flush_o      (flush_o)
	);

	mtimer_apb u_mtimer_apb (
		.clk_i     (clk_i),
		.reset_i   (reset_i),
		.apb_req_i (apb_req_i),
		.apb_rsp_o (apb_rsp_o),
		.mtip_o    (mtip)
	);

endmodule

/* rtl/mtimer_apb.sv */
`timescale 1ns/1ps
`include "csr_defines.svh"

module mtimer_apb (
	input  logic              clk_i,
	input  logic              reset_i,
	input  csr_pkg::apb_req_t apb_req_i,
	output csr_pkg::apb_rsp_t apb_rsp_o,
	output logic              mtip_o
);

	logic [31:0] mtime_q;
	logic [31:0] mtimecmp_q;
	logic        access;
	logic        hit_mtime;
	logic        hit_cmp;
	logic        wr_mtime;
	logic        wr_cmp;

	// zero-wait slave, everything happens in the access phase
	assign access    = apb_req_i.psel & apb_req_i.penable;
	assign hit_mtime = (apb_req_i.paddr == `TMR_MTIME_OFS);
	assign hit_cmp   = (apb_req_i.paddr == `TMR_MTIMECMP_OFS);
	assign wr_mtime  = access & apb_req_i.pwrite & hit_mtime;
	assign wr_cmp    = access & apb_req_i.pwrite & hit_cmp;

	always_ff @(posedge clk_i or negedge reset_i)
	begin
		if (!reset_i)
			mtime_q <= '0;
		else if (wr_mtime)
			mtime_q <= apb_req_i.pwdata; // reload
		else
			mtime_q <= mtime_q + 32'd1;
	end

	always_ff @(posedge clk_i or negedge reset_i)
	begin
		if (!reset_i)
			mtimecmp_q <= '1; // no interrupt until programmed
		else if (wr_cmp)
			mtimecmp_q <= apb_req_i.pwdata;
	end

	// registered compare, unsigned
	always_ff @(posedge clk_i or negedge reset_i)
	begin
		if (!reset_i)
			mtip_o <= 1'b0;
		else
			mtip_o <= (mtime_q >= mtimecmp_q);
	end

	always_comb
	begin
		apb_rsp_o.pready  = 1'b1;
		apb_rsp_o.pslverr = access & ~(hit_mtime | hit_cmp);
		apb_rsp_o.prdata  = '0;
		if (access && hit_mtime)
			apb_rsp_o.prdata = mtime_q;
		else if (access && hit_cmp)
			apb_rsp_o.prdata = mtimecmp_q;
	end

endmodule

/* rtl/pipe_flush_ctrl.sv */
`timescale 1ns/1ps

module pipe_flush_ctrl (
	input  logic                 take_irq_i,
	input  csr_pkg::trap_state_e trap_state_i,
	input  csr_pkg::pipe_stat_t  pipe_stat_i,
	output csr_pkg::flush_t      flush_o
);

	logic mret_take;
	logic in_enter;
	logic flush_mem;
	logic flush_ex;

	// a branch in the same cycle wins over mret in ID
	assign mret_take = pipe_stat_i.mret_id & ~pipe_stat_i.take_branch;
	assign in_enter  = (trap_state_i == csr_pkg::TRAP_ENTER);

	// only real stores get killed in MEM
	assign flush_mem = take_irq_i & pipe_stat_i.mem_wen & ~pipe_stat_i.mem_dummy;
	assign flush_ex  = flush_mem
		| (take_irq_i & ~pipe_stat_i.ex_dummy & ~pipe_stat_i.misaligned_ex);

	always_comb
	begin
		flush_o.flush_mem = flush_mem;
		flush_o.flush_ex  = flush_ex;
		flush_o.flush_id  = flush_ex | take_irq_i;
		flush_o.flush_if  = take_irq_i | in_enter | mret_take;
		flush_o.mret_sel  = mret_take;
		flush_o.seq_sel   = ~(in_enter | mret_take); // low picks handler or mepc
	end

endmodule

/* rtl/trap_ctrl.sv */
`timescale 1ns/1ps
`include "csr_defines.svh"

module trap_ctrl (
	input  logic                 clk_i,
	input  logic                 reset_i,
	input  logic                 status_mie_i,
	input  csr_pkg::irq_bits_u   mie_i,
	input  csr_pkg::irq_bits_u   mip_i,
	input  logic [31:0]          mtvec_i,
	input  logic [31:0]          mcause_i,
	output logic                 take_irq_o,
	output logic                 trap_enter_o,
	output logic [30:0]          trap_cause_o,
	output csr_pkg::trap_state_e trap_state_o,
	output logic [31:0]          irq_addr_o,
	output logic                 ack_o
);

	csr_pkg::trap_state_e state_q;
	logic                 ext_pend;
	logic                 tmr_pend;
	logic [30:0]          cause_q;
	logic [31:0]          vec_base;

	assign ext_pend   = mie_i.f.ext & mip_i.f.ext;
	assign tmr_pend   = mie_i.f.timer & mip_i.f.timer;
	assign take_irq_o = status_mie_i & (ext_pend | tmr_pend);

	always_ff @(posedge clk_i or negedge reset_i)
	begin
		if (!reset_i)
			state_q <= csr_pkg::INIT;
		else
		begin
			case (state_q)
				csr_pkg::INIT:
					state_q <= csr_pkg::STAND_BY;
				csr_pkg::STAND_BY:
				begin
					if (take_irq_o)
						state_q <= csr_pkg::TRAP_ENTER;
				end
				csr_pkg::TRAP_ENTER:
					state_q <= csr_pkg::TRAP_SETTLE; // csr_file captures here
				default:
					state_q <= csr_pkg::STAND_BY;
			endcase
		end
	end

	// cause frozen on entry so a dropping line can't change it mid-trap
	always_ff @(posedge clk_i)
	begin
		if (state_q == csr_pkg::STAND_BY && take_irq_o)
			cause_q <= ext_pend ? `CAUSE_M_EXT : `CAUSE_M_TIMER; // external first
	end

	assign trap_enter_o = (state_q == csr_pkg::TRAP_ENTER);
	assign trap_cause_o = cause_q;
	assign trap_state_o = state_q;
	assign ack_o        = trap_enter_o && (cause_q == `CAUSE_M_EXT);

	// direct mode jumps to base, vectored adds 4 * cause
	assign vec_base   = {mtvec_i[31:2], 2'b00};
	assign irq_addr_o = mtvec_i[0] ? vec_base + {mcause_i[29:0], 2'b00} : vec_base;

endmodule

/* rtl/csr_file.sv */
`timescale 1ns/1ps
`include "csr_defines.svh"

module csr_file (
	input  logic                clk_i,
	input  logic                reset_i,
	input  csr_pkg::csr_req_t   csr_req_i,
	input  logic [31:0]         pc_i,
	input  logic                mret_wb_i,
	input  logic                meip_i,
	input  logic                mtip_i,
	input  logic                trap_enter_i,
	input  logic [30:0]         trap_cause_i,
	output logic [31:0]         csr_rdata_o,
	output logic                status_mie_o,
	output csr_pkg::irq_bits_u  mie_o,
	output csr_pkg::irq_bits_u  mip_o,
	output logic [31:0]         mtvec_o,
	output logic [31:0]         mepc_o,
	output logic [31:0]         mcause_o
);

	logic               status_mie_q;
	logic               status_mpie_q;
	csr_pkg::irq_bits_u mie_q;
	csr_pkg::irq_bits_u mip_q;
	logic [31:0]        mtvec_q;
	logic [31:0]        mscratch_q;
	logic [31:0]        mepc_q;
	logic [31:0]        mcause_q;
	csr_pkg::irq_bits_u wdata_irq;
	logic [31:0]        mstatus_rd;

	assign wdata_irq = csr_req_i.wdata;

	// only mie, mpie and the fixed mpp are visible
	assign mstatus_rd = {19'b0, `MPP_MACHINE, 3'b0, status_mpie_q, 3'b0, status_mie_q, 3'b0};

	// interrupt lines sampled every cycle, mip is read-only
	always_ff @(posedge clk_i or negedge reset_i)
	begin
		if (!reset_i)
			mip_q <= '0;
		else
		begin
			mip_q.f.ext   <= meip_i;
			mip_q.f.timer <= mtip_i;
		end
	end

	always_ff @(posedge clk_i or negedge reset_i)
	begin
		if (!reset_i)
		begin
			status_mie_q  <= 1'b0;
			status_mpie_q <= 1'b0;
			mie_q         <= '0;
			mtvec_q       <= '0;
			mscratch_q    <= '0;
			mepc_q        <= '0;
			mcause_q      <= '0;
		end
		else if (trap_enter_i)
		begin
			mepc_q        <= {pc_i[31:2], 2'b00};
			mcause_q      <= {1'b1, trap_cause_i}; // interrupt bit set
			status_mpie_q <= status_mie_q;
			status_mie_q  <= 1'b0;
		end
		else if (mret_wb_i)
		begin
			status_mie_q  <= status_mpie_q;
			status_mpie_q <= 1'b1;
		end
		else if (csr_req_i.wen)
		begin
			case (csr_req_i.waddr)
				`CSR_MSTATUS:
				begin
					status_mie_q  <= csr_req_i.wdata[3];
					status_mpie_q <= csr_req_i.wdata[7];
				end
				`CSR_MIE:
				begin
					mie_q.f.ext   <= wdata_irq.f.ext;
					mie_q.f.timer <= wdata_irq.f.timer;
				end
				`CSR_MTVEC:    mtvec_q    <= {csr_req_i.wdata[31:2], 1'b0, csr_req_i.wdata[0]};
				`CSR_MSCRATCH: mscratch_q <= csr_req_i.wdata;
				`CSR_MEPC:     mepc_q     <= {csr_req_i.wdata[31:2], 2'b00};
				`CSR_MCAUSE:   mcause_q   <= csr_req_i.wdata;
				default:       ; // mip and unmapped writes dropped
			endcase
		end
	end

	// registered read port, one cycle latency
	always_ff @(posedge clk_i or negedge reset_i)
	begin
		if (!reset_i)
			csr_rdata_o <= '0;
		else
		begin
			case (csr_req_i.raddr)
				`CSR_MSTATUS:  csr_rdata_o <= mstatus_rd;
				`CSR_MIE:      csr_rdata_o <= mie_q.raw;
				`CSR_MTVEC:    csr_rdata_o <= mtvec_q;
				`CSR_MSCRATCH: csr_rdata_o <= mscratch_q;
				`CSR_MEPC:     csr_rdata_o <= mepc_q;
				`CSR_MCAUSE:   csr_rdata_o <= mcause_q;
				`CSR_MIP:      csr_rdata_o <= mip_q.raw;
				default:       csr_rdata_o <= '0;
			endcase
		end
	end

	assign status_mie_o = status_mie_q;
	assign mie_o        = mie_q;
	assign mip_o        = mip_q;
	assign mtvec_o      = mtvec_q;
	assign mepc_o       = mepc_q;
	assign mcause_o     = mcause_q;

endmodule

/* rtl/csr_pkg.sv */
package csr_pkg;

	// field view of mie / mip
	typedef struct packed {
		logic [19:0] rsvd_hi;   // bits 31:12
		logic        ext;       // meip / meie
		logic [2:0]  rsvd_mid;  // bits 10:8
		logic        timer;     // mtip / mtie
		logic [6:0]  rsvd_lo;   // bits 6:0
	} irq_fields_t;

	typedef union packed {
		logic [31:0] raw;
		irq_fields_t f;
	} irq_bits_u;

	// CSR port from the core, one read and one write per cycle
	typedef struct packed {
		logic [11:0] raddr;
		logic [11:0] waddr;
		logic [31:0] wdata;
		logic        wen;
	} csr_req_t;

	typedef struct packed {
		logic [31:0] pc;         // pc of the instruction being interrupted
		logic        take_branch;
		logic        mret_id;
		logic        mret_wb;
		logic        mem_wen;
		logic        ex_dummy;   // bubble in EX
		logic        mem_dummy;  // bubble in MEM
		logic        misaligned_ex;
	} pipe_stat_t;

	typedef struct packed {
		logic flush_if;
		logic flush_id;
		logic flush_ex;
		logic flush_mem;
		logic mret_sel;  // pc <- mepc
		logic seq_sel;   // low selects trap or mret target
	} flush_t;

	typedef enum logic [1:0] {
		INIT,
		STAND_BY,
		TRAP_ENTER,
		TRAP_SETTLE
	} trap_state_e;

	typedef struct packed {
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [31:0] paddr;
		logic [31:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [31:0] prdata;
		logic        pready;
		logic        pslverr;
	} apb_rsp_t;

endpackage

/* include/csr_defines.svh */
`ifndef CSR_DEFINES_SVH
`define CSR_DEFINES_SVH

// machine CSR addresses
`define CSR_MSTATUS   12'h300
`define CSR_MIE       12'h304
`define CSR_MTVEC     12'h305
`define CSR_MSCRATCH  12'h340
`define CSR_MEPC      12'h341
`define CSR_MCAUSE    12'h342
`define CSR_MIP       12'h344

// interrupt cause codes, interrupt bit added separately
`define CAUSE_M_EXT    31'd11
`define CAUSE_M_TIMER  31'd7

// timer register byte offsets on APB
`define TMR_MTIME_OFS     32'h0000_0000
`define TMR_MTIMECMP_OFS  32'h0000_0004

// mstatus.mpp, only machine mode exists
`define MPP_MACHINE  2'd3

`endif
